//--- rtl/ts_ports_pkg.sv
package ts_ports_pkg;

  // i/o port low bytes
  localparam logic [7:0] port_fe = 8'hFE;
  localparam logic [7:0] port_xt = 8'hAF; // #nnAF with the register in the high byte

  // extended register numbers
  localparam logic [7:0] reg_border  = 8'h0F;
  localparam logic [7:0] reg_vpage   = 8'h01;
  localparam logic [7:0] reg_sysconf = 8'h20;
  localparam logic [7:0] reg_memconf = 8'h21;
  localparam logic [7:0] reg_intmask = 8'h2A;

  // im2 vectors per source
  localparam logic [7:0] vect_frm = 8'hFF;
  localparam logic [7:0] vect_lin = 8'hFD;
  localparam logic [7:0] vect_dma = 8'hFB;

  localparam logic [7:0] intmask_rst = 8'h01; // frame int on

  // one address word read two ways
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [7:0] reg_num;
      logic [7:0] port_lo;
    } xt;
  } zport_addr_u;

  // bus events in the fclk domain
  typedef struct packed {
    logic        iowr_s;     // 1 cycle pulse
    logic        iord;       // level
    logic        intack;     // level
    logic        intack_end; // 1 cycle pulse
    zport_addr_u addr;
    logic [7:0]  data;
  } zbus_ev_t;

  // frm in bit 0 like the intmask register
  typedef struct packed {
    logic dma;
    logic lin;
    logic frm;
  } int_src_t;

endpackage

//--- rtl/ts_ports_top.sv
module ts_ports_top
  import ts_ports_pkg::*;
#(
  parameter int SYNC_STAGES = 2,
  parameter int INT_LEN     = 32
) (
  input  logic        fclk,
  input  logic        rst_n,
  input  logic        iorq_n,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        m1_n,
  input  logic [15:0] a,
  input  logic [7:0]  d_in,
  input  int_src_t    int_start,
  output logic [7:0]  d_out,
  output logic        d_oe,
  output logic        int_n,
  output logic [7:0]  border,
  output logic        beep,
  output logic [1:0]  turbo
);

  zbus_ev_t   bus_ev;
  logic       rd_hit;
  logic [7:0] rd_data;
  int_src_t   intmask;
  logic [7:0] im2vect;

  zbus_sync #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_sync (
    .fclk   (fclk),
    .rst_n  (rst_n),
    .iorq_n (iorq_n),
    .rd_n   (rd_n),
    .wr_n   (wr_n),
    .m1_n   (m1_n),
    .a      (a),
    .d_in   (d_in),
    .bus_ev (bus_ev)
  );

  zport_regs u_regs (
    .fclk    (fclk),
    .rst_n   (rst_n),
    .bus_ev  (bus_ev),
    .rd_hit  (rd_hit),
    .rd_data (rd_data),
    .intmask (intmask),
    .border  (border),
    .beep    (beep),
    .turbo   (turbo)
  );

  zint_ctrl #(
    .INT_LEN(INT_LEN)
  ) u_int (
    .fclk      (fclk),
    .rst_n     (rst_n),
    .bus_ev    (bus_ev),
    .int_start (int_start),
    .intmask   (intmask),
    .im2vect   (im2vect),
    .int_n     (int_n)
  );

  zbus_out u_out (
    .fclk    (fclk),
    .rst_n   (rst_n),
    .bus_ev  (bus_ev),
    .rd_hit  (rd_hit),
    .rd_data (rd_data),
    .im2vect (im2vect),
    .d_out   (d_out),
    .d_oe    (d_oe)
  );

endmodule

//--- rtl/zbus_out.sv
module zbus_out
  import ts_ports_pkg::*;
(
  input  logic       fclk,
  input  logic       rst_n,
  input  zbus_ev_t   bus_ev,
  input  logic       rd_hit,
  input  logic [7:0] rd_data,
  input  logic [7:0] im2vect,
  output logic [7:0] d_out,
  output logic       d_oe
);

  logic       drive;
  logic [7:0] d_next;

  // port data first then the vector and #FF for unclaimed reads
  always_comb begin
    drive  = 1'b0;
    d_next = 8'hFF;
    if (bus_ev.iord) begin
      drive = 1'b1;
      if (rd_hit) begin
        d_next = rd_data;
      end
    end else if (bus_ev.intack) begin
      drive  = 1'b1;
      d_next = im2vect;
    end
  end

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      d_oe <= 1'b0;
    end else begin
      d_oe <= drive;
    end
  end

  always_ff @(posedge fclk) begin
    if (drive) begin
      d_out <= d_next; // held while the bus is released
    end
  end

endmodule

//--- rtl/zbus_sync.sv
module zbus_sync
  import ts_ports_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic        fclk,
  input  logic        rst_n,
  input  logic        iorq_n,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        m1_n,
  input  logic [15:0] a,
  input  logic [7:0]  d_in,
  output zbus_ev_t    bus_ev
);

  logic [3:0] strb_raw;
  logic [SYNC_STAGES-1:0][3:0] chain;

  logic iorq_s;
  logic rd_s;
  logic wr_s;
  logic m1_s;

  logic wr_lvl;
  logic rd_lvl;
  logic ack_lvl;
  logic wr_lvl_d;

  logic        iowr_q;
  logic        iord_q;
  logic        intack_q;
  logic        intack_end_q;
  logic [15:0] addr_q;
  logic [7:0]  data_q;

  assign strb_raw = {~m1_n, ~wr_n, ~rd_n, ~iorq_n}; // active high
  assign {m1_s, wr_s, rd_s, iorq_s} = chain[SYNC_STAGES-1];

  assign wr_lvl  = iorq_s & wr_s;
  assign rd_lvl  = iorq_s & rd_s & ~m1_s;
  assign ack_lvl = iorq_s & m1_s;

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      chain        <= '0;
      wr_lvl_d     <= 1'b0;
      iowr_q       <= 1'b0;
      iord_q       <= 1'b0;
      intack_q     <= 1'b0;
      intack_end_q <= 1'b0;
    end else begin
      chain[0] <= strb_raw;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        chain[i] <= chain[i-1];
      end
      wr_lvl_d     <= wr_lvl;
      iowr_q       <= wr_lvl & ~wr_lvl_d; // first cycle of the write
      iord_q       <= rd_lvl;
      intack_q     <= ack_lvl;
      intack_end_q <= intack_q & ~ack_lvl; // with intack falling
    end
  end

  // z80 holds a and d stable while the strobe is low
  always_ff @(posedge fclk) begin
    addr_q <= a; // live since reads decode from it
    if (wr_lvl && !wr_lvl_d) begin
      data_q <= d_in;
    end
  end

  assign bus_ev.iowr_s     = iowr_q;
  assign bus_ev.iord       = iord_q;
  assign bus_ev.intack     = intack_q;
  assign bus_ev.intack_end = intack_end_q;
  assign bus_ev.addr.raw   = addr_q;
  assign bus_ev.data       = data_q;

endmodule

//--- rtl/zint_ctrl.sv
module zint_ctrl
  import ts_ports_pkg::*;
#(
  parameter int INT_LEN = 32
) (
  input  logic       fclk,
  input  logic       rst_n,
  input  zbus_ev_t   bus_ev,
  input  int_src_t   int_start,
  input  int_src_t   intmask,
  output logic [7:0] im2vect,
  output logic       int_n
);

  localparam int CNT_W = (INT_LEN > 1) ? $clog2(INT_LEN) : 1;

  int_src_t   pend;
  int_src_t   set_req;
  int_src_t   served;
  int_src_t   serve_sel;
  logic [7:0] vect_sel;
  logic [7:0] vect_q;
  logic       intack_d;
  logic       ack_rise;
  logic [CNT_W-1:0] frm_cnt;
  logic       frm_tmo;

  assign set_req  = int_start & intmask;
  assign ack_rise = bus_ev.intack & ~intack_d;
  assign frm_tmo  = pend.frm && (frm_cnt == CNT_W'(INT_LEN - 1));

  // fixed priority frm > lin > dma
  always_comb begin
    serve_sel = '0;
    vect_sel  = vect_frm;
    if (pend.frm) begin
      serve_sel.frm = 1'b1;
    end else if (pend.lin) begin
      serve_sel.lin = 1'b1;
      vect_sel      = vect_lin;
    end else if (pend.dma) begin
      serve_sel.dma = 1'b1;
      vect_sel      = vect_dma;
    end
  end

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      pend     <= '0;
      served   <= '0;
      vect_q   <= vect_frm;
      intack_d <= 1'b0;
      frm_cnt  <= '0;
    end else begin
      intack_d <= bus_ev.intack;
      if (ack_rise) begin
        served <= serve_sel;
        vect_q <= vect_sel;
      end

      pend <= (pend & ~(bus_ev.intack_end ? served : int_src_t'('0))) | set_req;
      if (frm_tmo && !set_req.frm) begin
        pend.frm <= 1'b0; // frame int length ran out
      end

      if (set_req.frm || !pend.frm) begin
        frm_cnt <= '0;
      end else begin
        frm_cnt <= frm_cnt + 1'b1;
      end
    end
  end

  // new vector already visible on the first acknowledge cycle
  assign im2vect = ack_rise ? vect_sel : vect_q;
  assign int_n   = ~|pend;

endmodule

//--- rtl/zport_regs.sv
module zport_regs
  import ts_ports_pkg::*;
(
  input  logic       fclk,
  input  logic       rst_n,
  input  zbus_ev_t   bus_ev,
  output logic       rd_hit,
  output logic [7:0] rd_data,
  output int_src_t   intmask,
  output logic [7:0] border,
  output logic       beep,
  output logic [1:0] turbo
);

  logic [7:0] vpage;
  logic [7:0] sysconf;
  logic [7:0] memconf;

  logic fe_sel;
  logic xt_sel;

  // #FE decodes on the low byte only
  assign fe_sel = bus_ev.addr.raw[7:0] == port_fe;
  assign xt_sel = bus_ev.addr.xt.port_lo == port_xt;

  always_ff @(posedge fclk or negedge rst_n) begin
    if (!rst_n) begin
      border  <= '0;
      beep    <= 1'b0;
      vpage   <= '0;
      sysconf <= '0;
      memconf <= '0;
      intmask <= int_src_t'(intmask_rst[2:0]);
    end else if (bus_ev.iowr_s) begin
      if (fe_sel) begin
        border <= {5'b0, bus_ev.data[2:0]};
        beep   <= bus_ev.data[4];
      end else if (xt_sel) begin
        case (bus_ev.addr.xt.reg_num)
          reg_border: begin
            border <= bus_ev.data;
          end
          reg_vpage: begin
            vpage <= bus_ev.data;
          end
          reg_sysconf: begin
            sysconf <= bus_ev.data;
          end
          reg_memconf: begin
            memconf <= bus_ev.data;
          end
          reg_intmask: begin
            intmask <= int_src_t'(bus_ev.data[2:0]);
          end
          default: begin
            // unknown register drops the write
          end
        endcase
      end
    end
  end

  assign turbo = sysconf[1:0];

  // combinational read mux on the live address
  always_comb begin
    rd_hit  = 1'b0;
    rd_data = '0;
    if (xt_sel) begin
      rd_hit = 1'b1;
      case (bus_ev.addr.xt.reg_num)
        reg_border: begin
          rd_data = border;
        end
        reg_vpage: begin
          rd_data = vpage;
        end
        reg_sysconf: begin
          rd_data = sysconf;
        end
        reg_memconf: begin
          rd_data = memconf;
        end
        reg_intmask: begin
          rd_data = {5'b0, intmask};
        end
        default: begin
          rd_hit = 1'b0; // left to the #FF driver
        end
      endcase
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f ts_ports.f --top-module tb_ts_ports; then
  echo "verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/Vtb_ts_ports); then
  echo "$out"
  echo "simulation exited with an error"
  exit 1
fi

echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
  exit 0
fi
exit 1

//--- test/tb_ts_ports.sv
module tb_ts_ports
  import ts_ports_pkg::*;
;

  localparam int sync_stages = 2;
  localparam int int_len     = 32;

  logic        fclk;
  logic        rst_n;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        m1_n;
  logic [15:0] a;
  logic [7:0]  d_in;
  int_src_t    int_start;
  logic [7:0]  d_out;
  logic        d_oe;
  logic        int_n;
  logic [7:0]  border;
  logic        beep;
  logic [1:0]  turbo;

  // shadow registers
  logic [7:0] sh_border;
  logic       sh_beep;
  logic [7:0] sh_vpage;
  logic [7:0] sh_sysconf;
  logic [7:0] sh_memconf;
  logic [7:0] sh_intmask;

  logic [31:0] rng;
  int checks;
  int err_cnt;
  int tmo_cnt;

  ts_ports_top #(
    .SYNC_STAGES(sync_stages),
    .INT_LEN    (int_len)
  ) uut (
    .fclk      (fclk),
    .rst_n     (rst_n),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .m1_n      (m1_n),
    .a         (a),
    .d_in      (d_in),
    .int_start (int_start),
    .d_out     (d_out),
    .d_oe      (d_oe),
    .int_n     (int_n),
    .border    (border),
    .beep      (beep),
    .turbo     (turbo)
  );

  always #5 fclk = ~fclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // expected value of an i/o read or #FF when nobody claims the port
  function automatic logic [7:0] expected_read(input logic [15:0] addr);
    if (addr[7:0] != 8'hAF) return 8'hFF;
    case (addr[15:8])
      8'h0F:   return sh_border;
      8'h01:   return sh_vpage;
      8'h20:   return sh_sysconf;
      8'h21:   return sh_memconf;
      8'h2A:   return {5'b0, sh_intmask[2:0]};
      default: return 8'hFF;
    endcase
  endfunction

  task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
    if (addr[7:0] == 8'hFE) begin
      sh_border = {5'b0, data[2:0]};
      sh_beep   = data[4];
    end else if (addr[7:0] == 8'hAF) begin
      case (addr[15:8])
        8'h0F:   sh_border  = data;
        8'h01:   sh_vpage   = data;
        8'h20:   sh_sysconf = data;
        8'h21:   sh_memconf = data;
        8'h2A:   sh_intmask = data & 8'h07;
        default: ;
      endcase
    end
  endtask

  task automatic compare_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge fclk);
    #1;
  endtask

  task automatic wait_oe(input logic level, output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < 20) begin
      @(posedge fclk);
      #1;
      n++;
      if (d_oe === level) ok = 1'b1;
    end
  endtask

  task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
    a      = addr;
    d_in   = data;
    iorq_n = 1'b0;
    wr_n   = 1'b0;
    idle(8);
    iorq_n = 1'b1;
    wr_n   = 1'b1;
    idle(8);
    model_write(addr, data);
  endtask

  task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
    bit ok;
    a      = addr;
    iorq_n = 1'b0;
    rd_n   = 1'b0;
    wait_oe(1'b1, ok);
    data = d_out;
    if (!ok) begin
      $display("timeout at %0t: d_oe never rose for the read of port %h", $time, addr);
      tmo_cnt++;
    end
    iorq_n = 1'b1;
    rd_n   = 1'b1;
    wait_oe(1'b0, ok);
    if (!ok) begin
      $display("timeout at %0t: d_oe stayed high after the read of port %h", $time, addr);
      tmo_cnt++;
    end
    idle(4);
  endtask

  task automatic int_ack(output logic [7:0] vec);
    bit ok;
    m1_n   = 1'b0;
    iorq_n = 1'b0;
    wait_oe(1'b1, ok);
    vec = d_out;
    if (!ok) begin
      $display("timeout at %0t: d_oe never rose during interrupt acknowledge", $time);
      tmo_cnt++;
    end
    m1_n   = 1'b1;
    iorq_n = 1'b1;
    wait_oe(1'b0, ok);
    if (!ok) begin
      $display("timeout at %0t: d_oe stayed high after interrupt acknowledge", $time);
      tmo_cnt++;
    end
    idle(2);
  endtask

  task automatic pulse_int(input logic frm, input logic lin, input logic dma);
    int_start.frm = frm;
    int_start.lin = lin;
    int_start.dma = dma;
    @(posedge fclk);
    #1;
    int_start = '0;
  endtask

  initial begin
    logic [7:0]  rdat;
    logic [15:0] addr;
    logic [7:0]  data;
    logic [7:0]  rnum;
    int n;
    fclk = 1'b0;
    rst_n = 1'b0;
    iorq_n = 1'b1;
    rd_n = 1'b1;
    wr_n = 1'b1;
    m1_n = 1'b1;
    a = '0;
    d_in = '0;
    int_start = '0;
    rng = 32'd88024;
    checks = 0;
    err_cnt = 0;
    tmo_cnt = 0;
    sh_border = '0;
    sh_beep = 1'b0;
    sh_vpage = '0;
    sh_sysconf = '0;
    sh_memconf = '0;
    sh_intmask = 8'h01;
    repeat (3) @(posedge fclk);
    #1;
    rst_n = 1'b1;
    idle(2);

    compare_value("int_n", {7'b0, int_n}, 8'h01);
    compare_value("d_oe", {7'b0, d_oe}, 8'h00);
    compare_value("beep", {7'b0, beep}, 8'h00);
    compare_value("border", border, 8'h00);
    compare_value("turbo", {6'b0, turbo}, 8'h00);
    io_read(16'h2AAF, rdat);
    compare_value("d_out", rdat, expected_read(16'h2AAF));

    // #FE with any high byte
    rng = xorshift32(rng);
    io_write({rng[15:8], 8'hFE}, rng[23:16]);
    compare_value("border", border, sh_border);
    compare_value("beep", {7'b0, beep}, {7'b0, sh_beep});

    for (int i = 0; i < 40; i++) begin
      rng = xorshift32(rng);
      case (rng[2:0])
        3'd0: rnum = 8'h0F;
        3'd1: rnum = 8'h01;
        3'd2: rnum = 8'h20;
        3'd3: rnum = 8'h21;
        3'd4: rnum = 8'h2A;
        default: rnum = rng[31:24]; // mostly unknown numbers
      endcase
      data = rng[15:8];
      io_write({rnum, 8'hAF}, data);
      io_read({rnum, 8'hAF}, rdat);
      compare_value("d_out", rdat, expected_read({rnum, 8'hAF}));
    end
    compare_value("turbo", {6'b0, turbo}, {6'b0, sh_sysconf[1:0]});
    compare_value("border", border, sh_border);

    for (int i = 0; i < 5; i++) begin
      rng = xorshift32(rng);
      addr = rng[15:0];
      if (addr[7:0] == 8'hAF) addr[7:0] = 8'hAE;
      io_read(addr, rdat);
      compare_value("d_out", rdat, 8'hFF);
    end

    io_write(16'h2AAF, 8'h07);
    pulse_int(1'b0, 1'b1, 1'b1);
    compare_value("int_n", {7'b0, int_n}, 8'h00);
    int_ack(rdat);
    compare_value("d_out", rdat, 8'hFD); // lin first
    compare_value("int_n", {7'b0, int_n}, 8'h00);
    int_ack(rdat);
    compare_value("d_out", rdat, 8'hFB);
    compare_value("int_n", {7'b0, int_n}, 8'h01);
    pulse_int(1'b1, 1'b0, 1'b0);
    compare_value("int_n", {7'b0, int_n}, 8'h00);
    int_ack(rdat);
    compare_value("d_out", rdat, 8'hFF);
    compare_value("int_n", {7'b0, int_n}, 8'h01);

    io_write(16'h2AAF, 8'h01);
    pulse_int(1'b0, 1'b1, 1'b0);
    idle(2);
    compare_value("int_n", {7'b0, int_n}, 8'h01); // lin masked
    pulse_int(1'b1, 1'b0, 1'b0);
    compare_value("int_n", {7'b0, int_n}, 8'h00);
    n = 0;
    while (int_n !== 1'b1 && n < int_len + 2) begin
      @(posedge fclk);
      #1;
      n++;
    end
    if (int_n !== 1'b1) begin
      $display("timeout at %0t: frame interrupt did not end on its own", $time);
      tmo_cnt++;
    end else if (n < int_len - 1) begin
      $display("error at %0t: int_n rose after %0d cycles, expected %0d", $time, n, int_len);
      err_cnt++;
    end

    $display("done: %0d checks, %0d value errors, %0d timeouts", checks, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- ts_ports.f
rtl/ts_ports_pkg.sv
rtl/zbus_sync.sv
rtl/zport_regs.sv
rtl/zint_ctrl.sv
rtl/zbus_out.sv
rtl/ts_ports_top.sv
test/tb_ts_ports.sv
